/* project.f */
+incdir+src
src/rename_pkg.sv
src/map_table.sv
src/arch_map.sv
src/free_list.sv
src/rename_ctrl.sv
src/rename_top.sv
verification/rename_tb.sv

/* run_sim.sh */
#!/bin/bash
# builds and runs the rename stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wall \
	-f project.f \
	--top-module rename_tb \
	-o rename_sim

./obj_dir/rename_sim 2>&1 | tee sim.log || true

if grep -q "sim failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished cleanly"
exit 0

/* verification/rename_tb.sv */
`default_nettype none

`include "rename_config.svh"

module rename_tb
	import rename_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD      = 100;
	localparam int STIM_CYCLES = 1200;
	localparam int TIMEOUT     = STIM_CYCLES * PERIOD + 20 * PERIOD;
	localparam int ST_WAIT     = 0;
	localparam int ST_RUN      = 1;
	localparam int ST_RECOVER  = 2;

	logic         clock;
	logic         reset;
	rename_slot_t dispatch_slot [2];
	logic         dispatch_valid;
	logic         dispatch_ready;
	rename_out_t  rename_result [2];
	cdb_entry_t   cdb [`RN_CDB_WIDTH];
	retire_slot_t retire [2];
	logic         recover;

	integer seed = 32'hc79b_9404;

	// reference model state
	pr_tag_t        m_map [`RN_AR_COUNT];
	logic [31:0]    m_ready;
	pr_tag_t        m_arch [`RN_AR_COUNT];
	pr_tag_t        fl [`RN_PR_COUNT];
	int             fl_head;
	int             fl_chead;
	int             fl_tail;
	int             m_state;
	bit             fired_last;
	retire_slot_t   infl [$];   // dispatched, not yet retired, oldest first

	logic           exp_ready;
	rename_out_t    exp_result [2];

	rename_top i_dut (
		.clock          (clock),
		.reset          (reset),
		.dispatch_slot  (dispatch_slot),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.rename_result  (rename_result),
		.cdb            (cdb),
		.retire         (retire),
		.recover        (recover)
	);

	initial
	begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// ------------------------------------------------------------
	// expected combinational rename result
	// ------------------------------------------------------------
	always_comb
	begin
		pr_tag_t t0;
		pr_tag_t t1;
		exp_ready = (m_state == ST_RUN) && ((fl_tail - fl_head) >= 2);
		t0 = fl[fl_head & 63];
		t1 = dispatch_slot[0].valid ? fl[(fl_head + 1) & 63] : t0;   // bubble skips a tag
		for (int s = 0; s < 2; s++)
		begin
			exp_result[s] = '0;
			exp_result[s].dest_pr = (s == 0) ? t0 : t1;
			exp_result[s].told_pr = m_map[dispatch_slot[s].dest_ar];
			exp_result[s].src1_pr = m_map[dispatch_slot[s].src1_ar];
			exp_result[s].src1_ready = m_ready[dispatch_slot[s].src1_ar];
			exp_result[s].src2_pr = m_map[dispatch_slot[s].src2_ar];
			exp_result[s].src2_ready = m_ready[dispatch_slot[s].src2_ar];
			if (s == 1 && dispatch_slot[0].valid)
			begin
				if (dispatch_slot[1].dest_ar == dispatch_slot[0].dest_ar)
					exp_result[s].told_pr = t0;
				if (dispatch_slot[1].src1_ar == dispatch_slot[0].dest_ar)
				begin
					exp_result[s].src1_pr    = t0;
					exp_result[s].src1_ready = 1'b0;
				end
				if (dispatch_slot[1].src2_ar == dispatch_slot[0].dest_ar)
				begin
					exp_result[s].src2_pr    = t0;
					exp_result[s].src2_ready = 1'b0;
				end
			end
			if (!dispatch_slot[s].src1_used)
			begin
				exp_result[s].src1_pr    = '0;
				exp_result[s].src1_ready = 1'b1;
			end
			if (!dispatch_slot[s].src2_used)
			begin
				exp_result[s].src2_pr    = '0;
				exp_result[s].src2_ready = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// model update at each edge
	// ------------------------------------------------------------
	always @(posedge clock)
	begin
		int           k;
		int           nret;
		bit           fire;
		retire_slot_t e;
		if (reset)
		begin
			for (int i = 0; i < `RN_AR_COUNT; i++)
			begin
				m_map[i]  = pr_tag_t'(i);
				m_arch[i] = pr_tag_t'(i);
				fl[i]     = pr_tag_t'(i + `RN_AR_COUNT);
			end
			m_ready    = '1;
			fl_head    = 0;
			fl_chead   = 0;
			fl_tail    = `RN_FREE_COUNT;
			m_state    = ST_WAIT;
			fired_last = 1'b0;
		end
		else
		begin
			fire = dispatch_valid && exp_ready;
			k    = 0;
			if (m_state == ST_RECOVER)
			begin
				m_map   = m_arch;   // arch map before this edge's retire
				m_ready = '1;
			end
			else
			begin
				for (int c = 0; c < `RN_CDB_WIDTH; c++)
					if (cdb[c].valid && m_map[cdb[c].ar] == cdb[c].pr)
						m_ready[cdb[c].ar] = 1'b1;
				for (int s = 0; s < 2; s++)
				begin
					if (fire && dispatch_slot[s].valid)
					begin
						e.valid = 1'b1;
						e.ar    = dispatch_slot[s].dest_ar;
						e.pr    = fl[(fl_head + k) & 63];
						e.told  = m_map[e.ar];
						m_map[e.ar]   = e.pr;
						m_ready[e.ar] = 1'b0;
						infl.push_back(e);
						k++;
					end
				end
			end
			nret = 0;
			for (int s = 0; s < 2; s++)
			begin
				if (retire[s].valid)
				begin
					m_arch[retire[s].ar] = retire[s].pr;
					fl[fl_tail & 63] = retire[s].told;
					fl_tail++;
					nret++;
				end
			end
			fl_chead += nret;
			fl_head = (m_state == ST_RECOVER) ? fl_chead : fl_head + k;
			fired_last = fire;
			if (recover)
				m_state = ST_RECOVER;
			else
				m_state = ST_RUN;
		end
	end

	// ------------------------------------------------------------
	// checks, sampled mid cycle
	// ------------------------------------------------------------
	assert property (@(negedge clock) disable iff (reset) dispatch_ready == exp_ready)
	else
	begin
		$display("ERR dispatch_ready got %h expected %h", dispatch_ready, exp_ready);
		$display("sim failed");
		$fatal(1);
	end

	assert property (@(negedge clock) disable iff (reset)
		!(dispatch_valid && exp_ready && dispatch_slot[0].valid) ||
		rename_result[0] == exp_result[0])
	else
	begin
		$display("ERR rename_result[0] got %h expected %h", rename_result[0], exp_result[0]);
		$display("sim failed");
		$fatal(1);
	end

	assert property (@(negedge clock) disable iff (reset)
		!(dispatch_valid && exp_ready && dispatch_slot[1].valid) ||
		rename_result[1] == exp_result[1])
	else
	begin
		$display("ERR rename_result[1] got %h expected %h", rename_result[1], exp_result[1]);
		$display("sim failed");
		$fatal(1);
	end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	function automatic rename_slot_t random_slot();
		rename_slot_t sl;
		sl.valid     = ({$random(seed)} % 4) != 0;
		sl.dest_ar   = ar_tag_t'($random(seed));
		sl.src1_ar   = ar_tag_t'($random(seed));
		sl.src1_used = ({$random(seed)} % 5) != 0;
		sl.src2_ar   = ar_tag_t'($random(seed));
		sl.src2_used = ({$random(seed)} % 3) != 0;
		return sl;
	endfunction

	task automatic drive_cdb(input bit enable);
		int idx;
		for (int c = 0; c < `RN_CDB_WIDTH; c++)
		begin
			cdb[c] = '0;
			if (enable && infl.size() > 0 && $random(seed) % 2 == 0)
			begin
				idx = {$random(seed)} % infl.size();
				cdb[c].valid = 1'b1;
				cdb[c].ar    = infl[idx].ar;
				cdb[c].pr    = ($random(seed) & 1) ? infl[idx].pr : infl[idx].told;   // told is stale
			end
		end
	endtask

	task automatic drive_retire(input int pct);
		retire[0] = '0;
		retire[1] = '0;
		for (int s = 0; s < 2; s++)
			if (infl.size() > 0 && ({$random(seed)} % 100) < pct && (s == 0 || retire[0].valid))
				retire[s] = infl.pop_front();
	endtask

	// one cycle of traffic; slots are held until accepted
	task automatic random_cycle(input bit want_dispatch, input int retire_pct);
		@(posedge clock);
		#10;
		if (!dispatch_valid || fired_last)
		begin
			dispatch_slot[0] = random_slot();
			dispatch_slot[1] = random_slot();
			dispatch_valid   = want_dispatch;
		end
		drive_retire(retire_pct);
		drive_cdb(1'b1);
	endtask

	task automatic dispatch_pair(input rename_slot_t s0, input rename_slot_t s1);
		int n;
		@(posedge clock);
		#10;
		dispatch_slot[0] = s0;
		dispatch_slot[1] = s1;
		dispatch_valid   = 1'b1;
		retire[0] = '0;
		retire[1] = '0;
		drive_cdb(1'b0);
		n = 0;
		do
		begin
			@(posedge clock);
			#10;
			n++;
			drive_retire(fired_last ? 0 : 100);   // free tags until the pair fits
		end
		while (!fired_last && n < 50);
		dispatch_valid = 1'b0;
		if (!fired_last)
		begin
			$display("dispatch pair was never accepted by the DUT");
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic recover_pulse();
		@(posedge clock);
		#10;
		recover        = 1'b1;
		dispatch_valid = 1'b0;
		retire[0]      = '0;
		retire[1]      = '0;
		infl.delete();   // everything in flight is wrong path
		@(posedge clock);
		#10;
		recover = 1'b0;
	endtask

	initial
	begin
		#TIMEOUT;
		$display("watchdog expired before the tests completed");
		$display("sim failed");
		$fatal(1);
	end

	initial
	begin
		rename_slot_t a;
		rename_slot_t b;
		int           n;
		reset          = 1'b1;
		recover        = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_slot[0] = '0;
		dispatch_slot[1] = '0;
		retire[0] = '0;
		retire[1] = '0;
		for (int c = 0; c < `RN_CDB_WIDTH; c++)
			cdb[c] = '0;
		repeat (8) @(posedge clock);
		#10;
		reset = 1'b0;
		while (!dispatch_ready)
			@(posedge clock);

		// identity lookups and first tags from 32
		for (int i = 0; i < 4; i++)
		begin
			a = '{1'b1, ar_tag_t'(2 * i), ar_tag_t'(i + 8), 1'b1, ar_tag_t'(i + 16), 1'b1};
			b = '{1'b1, ar_tag_t'(2 * i + 1), ar_tag_t'(i + 20), 1'b1, ar_tag_t'(i + 24), 1'b1};
			dispatch_pair(a, b);
		end

		repeat (300) random_cycle(1'b1, 45);

		// slot 1 reads and overwrites slot 0's destination
		a = '{1'b1, 5'd7, 5'd3, 1'b1, 5'd4, 1'b1};
		b = '{1'b1, 5'd7, 5'd7, 1'b1, 5'd7, 1'b1};
		dispatch_pair(a, b);
		b = '{1'b1, 5'd9, 5'd7, 1'b0, 5'd7, 1'b1};
		dispatch_pair(a, b);

		// back-pressure without retirement
		n = 0;
		while (dispatch_ready && n < 100)
		begin
			random_cycle(1'b1, 0);
			n++;
		end
		n = 0;
		while (!dispatch_ready && n < 100)
		begin
			random_cycle(1'b0, 90);
			n++;
		end
		repeat (150) random_cycle(1'b1, 40);

		recover_pulse();
		repeat (150) random_cycle(1'b1, 50);
		recover_pulse();
		repeat (100) random_cycle(1'b1, 50);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* src/rename_top.sv */
`default_nettype none

`include "rename_config.svh"

module rename_top
	import rename_pkg::*;
(
	input  wire logic         clock,
	input  wire logic         reset,
	input  wire rename_slot_t dispatch_slot [`RN_DISPATCH_WIDTH],
	input  wire logic         dispatch_valid,
	output logic              dispatch_ready,
	output rename_out_t       rename_result [`RN_DISPATCH_WIDTH],
	input  wire cdb_entry_t   cdb [`RN_CDB_WIDTH],
	input  wire retire_slot_t retire [`RN_DISPATCH_WIDTH],
	input  wire logic         recover
);

	logic                  dispatch_fire;
	logic [1:0]            alloc_num;
	logic                  restore;
	pr_tag_t               alloc_tag [`RN_DISPATCH_WIDTH];
	logic [`RN_PR_BITS:0]  free_count;
	pr_tag_t               arch_state [`RN_AR_COUNT];

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	rename_ctrl i_rename_ctrl (
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_slot  (dispatch_slot),
		.free_count     (free_count),
		.recover        (recover),
		.dispatch_ready (dispatch_ready),
		.dispatch_fire  (dispatch_fire),
		.alloc_num      (alloc_num),
		.restore        (restore)
	);

	free_list i_free_list (
		.clock      (clock),
		.reset      (reset),
		.alloc_num  (alloc_num),
		.retire     (retire),
		.restore    (restore),
		.alloc_tag  (alloc_tag),
		.free_count (free_count)
	);

	// ------------------------------------------------------------
	// maps
	// ------------------------------------------------------------
	map_table i_map_table (
		.clock         (clock),
		.reset         (reset),
		.dispatch_slot (dispatch_slot),
		.dispatch_fire (dispatch_fire),
		.alloc_tag     (alloc_tag),
		.cdb           (cdb),
		.restore       (restore),
		.arch_state    (arch_state),
		.rename_result (rename_result)
	);

	arch_map i_arch_map (
		.clock      (clock),
		.reset      (reset),
		.retire     (retire),
		.arch_state (arch_state)
	);

endmodule

`default_nettype wire

/* src/rename_ctrl.sv */
`default_nettype none

`include "rename_config.svh"

module rename_ctrl
	import rename_pkg::*;
(
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                dispatch_valid,
	input  wire rename_slot_t        dispatch_slot [`RN_DISPATCH_WIDTH],
	input  wire logic [`RN_PR_BITS:0] free_count,
	input  wire logic                recover,
	output logic                     dispatch_ready,
	output logic                     dispatch_fire,
	output logic [1:0]               alloc_num,
	output logic                     restore
);

	typedef enum logic [1:0] {
		RESET_WAIT,
		RUN,
		RECOVER
	} state_t;

	state_t state_q;
	state_t state_next;

	// ------------------------------------------------------------
	// run / recover FSM
	// ------------------------------------------------------------
	always_comb
	begin
		state_next = state_q;
		case (state_q)
			RESET_WAIT: state_next = RUN;   // one dead cycle after reset
			RUN:        if (recover) state_next = RECOVER;
			RECOVER:    state_next = recover ? RECOVER : RUN;
			default:    state_next = RESET_WAIT;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state_q <= RESET_WAIT;
		else
			state_q <= state_next;
	end

	// need two tags even if one slot is a bubble
	assign dispatch_ready = (state_q == RUN) && (free_count >= (`RN_PR_BITS+1)'(2));
	assign dispatch_fire  = dispatch_valid && dispatch_ready;

	assign alloc_num = dispatch_fire ?
		2'(dispatch_slot[0].valid) + 2'(dispatch_slot[1].valid) : 2'd0;

	assign restore = (state_q == RECOVER);

endmodule

`default_nettype wire

/* src/free_list.sv */
`default_nettype none

`include "rename_config.svh"

module free_list
	import rename_pkg::*;
(
	input  wire logic         clock,
	input  wire logic         reset,
	input  wire logic [1:0]   alloc_num,
	input  wire retire_slot_t retire [`RN_DISPATCH_WIDTH],
	input  wire logic         restore,
	output pr_tag_t           alloc_tag [`RN_DISPATCH_WIDTH],
	output logic [`RN_PR_BITS:0] free_count
);

	// pointers carry one wrap bit above the index
	typedef logic [`RN_PR_BITS:0]   ptr_t;
	typedef logic [`RN_PR_BITS-1:0] idx_t;

	pr_tag_t    fifo_q [`RN_PR_COUNT];
	ptr_t       tail_q;
	ptr_t       spec_head_q;      // next tag handed to dispatch
	ptr_t       commit_head_q;    // head as seen by retirement
	ptr_t       commit_head_next;
	logic [1:0] retire_num;
	idx_t       head_idx;
	idx_t       tail_idx;

	assign head_idx = spec_head_q[`RN_PR_BITS-1:0];
	assign tail_idx = tail_q[`RN_PR_BITS-1:0];

	// ------------------------------------------------------------
	// next two free tags and occupancy
	// ------------------------------------------------------------
	assign alloc_tag[0] = fifo_q[head_idx];
	assign alloc_tag[1] = fifo_q[head_idx + idx_t'(1)];

	assign free_count = tail_q - spec_head_q;

	assign retire_num = 2'(retire[0].valid) + 2'(retire[1].valid);

	// every retire consumed one allocation, so commit head moves too
	assign commit_head_next = commit_head_q + ptr_t'(retire_num);

	// ------------------------------------------------------------
	// pointer and queue update
	// ------------------------------------------------------------
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail_q        <= ptr_t'(`RN_FREE_COUNT);
			spec_head_q   <= '0;
			commit_head_q <= '0;
		end
		else
		begin
			tail_q        <= tail_q + ptr_t'(retire_num);
			commit_head_q <= commit_head_next;
			if (restore)
				spec_head_q <= commit_head_next;   // drop wrong-path allocations
			else
				spec_head_q <= spec_head_q + ptr_t'(alloc_num);
		end
	end

	// queue storage, only the initial free tags are loaded on reset
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `RN_FREE_COUNT; i++)
				fifo_q[i] <= pr_tag_t'(i + `RN_AR_COUNT);   // tags 32..63
		end
		else
		begin
			if (retire[0].valid)
				fifo_q[tail_idx] <= retire[0].told;
			if (retire[1].valid)
				fifo_q[tail_idx + idx_t'(retire[0].valid)] <= retire[1].told;
		end
	end

endmodule

`default_nettype wire

/* src/arch_map.sv */
`default_nettype none

`include "rename_config.svh"

module arch_map
	import rename_pkg::*;
(
	input  wire logic         clock,
	input  wire logic         reset,
	input  wire retire_slot_t retire [`RN_DISPATCH_WIDTH],
	output pr_tag_t           arch_state [`RN_AR_COUNT]
);

	// ------------------------------------------------------------
	// committed map, read whole by map_table on restore
	// ------------------------------------------------------------
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `RN_AR_COUNT; i++)
				arch_state[i] <= pr_tag_t'(i);
		end
		else
		begin
			// later slot is younger, so it lands on top
			for (int s = 0; s < `RN_DISPATCH_WIDTH; s++)
			begin
				if (retire[s].valid)
					arch_state[retire[s].ar] <= retire[s].pr;
			end
		end
	end

endmodule

`default_nettype wire

/* src/map_table.sv */
`default_nettype none

`include "rename_config.svh"

module map_table
	import rename_pkg::*;
(
	input  wire logic         clock,
	input  wire logic         reset,
	input  wire rename_slot_t dispatch_slot [`RN_DISPATCH_WIDTH],
	input  wire logic         dispatch_fire,
	input  wire pr_tag_t      alloc_tag [`RN_DISPATCH_WIDTH],
	input  wire cdb_entry_t   cdb [`RN_CDB_WIDTH],
	input  wire logic         restore,
	input  wire pr_tag_t      arch_state [`RN_AR_COUNT],
	output rename_out_t       rename_result [`RN_DISPATCH_WIDTH]
);

	pr_tag_t                       map_q [`RN_AR_COUNT];   // speculative map
	logic [`RN_AR_COUNT-1:0]       ready_q;
	logic [`RN_AR_COUNT-1:0]       ready_next;

	pr_tag_t                       new_tag [`RN_DISPATCH_WIDTH];
	logic [`RN_DISPATCH_WIDTH-1:0] byp_src1;
	logic [`RN_DISPATCH_WIDTH-1:0] byp_src2;
	logic [`RN_DISPATCH_WIDTH-1:0] byp_told;

	// ------------------------------------------------------------
	// tag assignment and intra-pair bypass
	// ------------------------------------------------------------

	// a bubble in slot 0 hands the first free tag to slot 1
	assign new_tag[0] = alloc_tag[0];
	assign new_tag[1] = dispatch_slot[0].valid ? alloc_tag[1] : alloc_tag[0];

	// slot 0 is oldest, nothing to bypass from
	assign byp_src1[0] = 1'b0;
	assign byp_src2[0] = 1'b0;
	assign byp_told[0] = 1'b0;

	assign byp_src1[1] = dispatch_slot[0].valid &&
		(dispatch_slot[1].src1_ar == dispatch_slot[0].dest_ar);
	assign byp_src2[1] = dispatch_slot[0].valid &&
		(dispatch_slot[1].src2_ar == dispatch_slot[0].dest_ar);
	assign byp_told[1] = dispatch_slot[0].valid &&
		(dispatch_slot[1].dest_ar == dispatch_slot[0].dest_ar);

	always_comb
	begin
		for (int s = 0; s < `RN_DISPATCH_WIDTH; s++)
		begin
			// source 1
			if (!dispatch_slot[s].src1_used)
			begin
				rename_result[s].src1_pr    = '0;
				rename_result[s].src1_ready = 1'b1;
			end
			else if (byp_src1[s])
			begin
				rename_result[s].src1_pr    = new_tag[0];
				rename_result[s].src1_ready = 1'b0;   // producer still in flight
			end
			else
			begin
				rename_result[s].src1_pr    = map_q[dispatch_slot[s].src1_ar];
				rename_result[s].src1_ready = ready_q[dispatch_slot[s].src1_ar];
			end

			// source 2
			if (!dispatch_slot[s].src2_used)
			begin
				rename_result[s].src2_pr    = '0;
				rename_result[s].src2_ready = 1'b1;
			end
			else if (byp_src2[s])
			begin
				rename_result[s].src2_pr    = new_tag[0];
				rename_result[s].src2_ready = 1'b0;
			end
			else
			begin
				rename_result[s].src2_pr    = map_q[dispatch_slot[s].src2_ar];
				rename_result[s].src2_ready = ready_q[dispatch_slot[s].src2_ar];
			end

			rename_result[s].dest_pr = new_tag[s];
			rename_result[s].told_pr = byp_told[s] ? new_tag[0] :
				map_q[dispatch_slot[s].dest_ar];
		end
	end

	// ------------------------------------------------------------
	// ready bits: cdb sets first, dispatch clears win
	// ------------------------------------------------------------
	always_comb
	begin
		ready_next = ready_q;
		for (int c = 0; c < `RN_CDB_WIDTH; c++)
		begin
			// stale broadcasts for a remapped ar are dropped
			if (cdb[c].valid && (map_q[cdb[c].ar] == cdb[c].pr))
				ready_next[cdb[c].ar] = 1'b1;
		end
		for (int s = 0; s < `RN_DISPATCH_WIDTH; s++)
		begin
			if (dispatch_fire && dispatch_slot[s].valid)
				ready_next[dispatch_slot[s].dest_ar] = 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `RN_AR_COUNT; i++)
				map_q[i] <= pr_tag_t'(i);   // identity map
			ready_q <= '1;
		end
		else if (restore)
		begin
			map_q   <= arch_state;
			ready_q <= '1;   // everything retired is ready
		end
		else
		begin
			ready_q <= ready_next;
			// slot 1 written last so it keeps the map on equal dests
			for (int s = 0; s < `RN_DISPATCH_WIDTH; s++)
			begin
				if (dispatch_fire && dispatch_slot[s].valid)
					map_q[dispatch_slot[s].dest_ar] <= new_tag[s];
			end
		end
	end

endmodule

`default_nettype wire

/* src/rename_pkg.sv */
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

	typedef logic [`RN_AR_BITS-1:0] ar_tag_t;   // architectural register index
	typedef logic [`RN_PR_BITS-1:0] pr_tag_t;   // physical register tag

	// one decoded instruction from the dispatch side
	typedef struct packed {
		logic    valid;
		ar_tag_t dest_ar;
		ar_tag_t src1_ar;
		logic    src1_used;   // low means no register operand
		ar_tag_t src2_ar;
		logic    src2_used;
	} rename_slot_t;

	// rename result for one slot, goes to RS and ROB
	typedef struct packed {
		pr_tag_t src1_pr;
		logic    src1_ready;
		pr_tag_t src2_pr;
		logic    src2_ready;
		pr_tag_t dest_pr;
		pr_tag_t told_pr;    // previous mapping of dest
	} rename_out_t;

	// one common data bus port
	typedef struct packed {
		logic    valid;
		ar_tag_t ar;
		pr_tag_t pr;
	} cdb_entry_t;

	// one retiring instruction from the ROB
	typedef struct packed {
		logic    valid;
		ar_tag_t ar;
		pr_tag_t pr;
		pr_tag_t told;
	} retire_slot_t;

endpackage

`default_nettype wire

/* src/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// ------------------------------------------------------------
// register file sizes
// ------------------------------------------------------------
`define RN_AR_COUNT       32
`define RN_PR_COUNT       64
`define RN_AR_BITS        5   // log2 of RN_AR_COUNT
`define RN_PR_BITS        6   // log2 of RN_PR_COUNT

// tags that start out on the free list
`define RN_FREE_COUNT     (`RN_PR_COUNT - `RN_AR_COUNT)

// ------------------------------------------------------------
// machine width
// ------------------------------------------------------------
`define RN_CDB_WIDTH      6
`define RN_DISPATCH_WIDTH 2

`endif
